// ==== filelist.f ====
source/afu_pkg.sv
source/channel_if.sv
source/command_channel.sv
source/command_arbiter.sv
source/tag_table.sv
source/response_router.sv
source/afu_command_path.sv
testbench/afu_command_path_assertions.sv
testbench/afu_command_path_tb.sv

// ==== testbench/afu_command_path_tb.sv ====
// testbench for the command path: clock, reset, stimulus, host model, reference and checker
`timescale 1ns/1ps

module afu_command_path_tb;

	logic                          clock;
	logic                          rstn;
	logic                          enabled;
	logic                          cmd_valid;
	logic [1:0]                    cmd_class;
	logic [63:0]                   cmd_address;
	afu_pkg::command_code_t        cmd_code;
	logic [2:0]                    cmd_almost_full;
	logic [7:0]                    room;
	logic                          issue_valid;
	logic [7:0]                    issue_tag;
	logic [63:0]                   issue_address;
	afu_pkg::command_code_t        issue_code;
	logic                          psl_rsp_valid;
	logic [7:0]                    psl_rsp_tag;
	afu_pkg::response_code_t       psl_rsp_code;
	logic [7:0]                    psl_rsp_credits;
	logic                          rsp_valid;
	logic [1:0]                    rsp_class;
	logic [7:0]                    rsp_tag;
	afu_pkg::response_code_t       rsp_code;
	logic [63:0]                   rsp_address;
	logic                          rsp_error;

	// scoreboard state
	int seed = 42716;
	int error_count;
	int timeout_count;
	int issue_count;
	int rsp_count;
	int cycle;
	logic host_on;
	int next_sequence [3];
	int outstanding [3];
	logic tag_busy [256];
	logic [1:0] tag_class_ref [256];
	logic [63:0] tag_address_ref [256];
	logic [7:0] pending_tag [$];
	int pending_due [$];
	logic [7:0] sent_tag [$];
	afu_pkg::response_code_t sent_code [$];
	int issue_classes [$];

	afu_command_path afu_command_path_i (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

//////////////////////////////
// helpers
//////////////////////////////

	// class in bits 61:60, sequence in the low half word
	function automatic logic [63:0] make_address(input logic [1:0] cls, input int seq);
		return {2'b00, cls, 28'h0C0FFEE, 16'h0000, seq[15:0]};
	endfunction

	function automatic afu_pkg::command_code_t class_code(input int cls);
		if (cls == 0)
			return afu_pkg::READ_CL;
		else if (cls == 1)
			return afu_pkg::WRITE_MI;
		return afu_pkg::READ_WED;
	endfunction

	// read 4, write 4, wed 1
	function automatic int class_limit(input int cls);
		return (cls == 2) ? 1 : 4;
	endfunction

	// expected delivery, from the table of issued commands
	function automatic void expected_response(
		input  logic [7:0]              tag,
		input  afu_pkg::response_code_t code,
		output logic                    known,
		output logic [1:0]              exp_class,
		output logic [63:0]             exp_address,
		output logic                    exp_error
	);
		known       = tag_busy[tag];
		exp_class   = tag_class_ref[tag];
		exp_address = tag_address_ref[tag];
		exp_error   = !known || (code != afu_pkg::DONE);
	endfunction

	task automatic report_mismatch(input string test, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
		error_count++;
	endtask

//////////////////////////////
// monitor and checker
//////////////////////////////

	always @(posedge clock) begin : monitor
		logic [3:0] cls;
		logic known;
		logic [1:0] exp_class;
		logic [63:0] exp_address;
		logic [63:0] issued_address;
		logic exp_error;
		logic [7:0] exp_tag;
		afu_pkg::response_code_t exp_code;
		cycle++;
		// responses first, so a freed credit never looks like an overrun
		if (rstn && rsp_valid) begin
			rsp_count++;
			if (sent_tag.size() == 0) begin
				$display("rsp_valid seen with no host response outstanding");
				error_count++;
			end else begin
				exp_tag  = sent_tag.pop_front();
				exp_code = sent_code.pop_front();
				expected_response(exp_tag, exp_code, known, exp_class, exp_address, exp_error);
				if (rsp_tag !== exp_tag)
					report_mismatch("response tag", exp_tag, rsp_tag);
				if (rsp_code !== exp_code)
					report_mismatch("response code", exp_code, rsp_code);
				if (rsp_error !== exp_error)
					report_mismatch("response error", exp_error, rsp_error);
				if (known) begin
					if (rsp_class !== exp_class)
						report_mismatch("response class", exp_class, rsp_class);
					if (rsp_address !== exp_address)
						report_mismatch("response address", exp_address, rsp_address);
					tag_busy[exp_tag] = 1'b0;
					outstanding[exp_class]--;
				end
			end
		end
		if (rstn && issue_valid) begin
			issue_count++;
			cls = issue_address[63:60];
			issued_address = issue_address;
			if (cls > 2) begin
				report_mismatch("issue class bits", 0, cls);
			end else begin
				// offered address for the next command of this class
				issued_address = make_address(cls[1:0], next_sequence[cls]);
				if (issue_address !== issued_address)
					report_mismatch("issue address", issued_address, issue_address);
				if (issue_code !== class_code(cls))
					report_mismatch("issue code", class_code(cls), issue_code);
				next_sequence[cls]++;
				outstanding[cls]++;
				if (outstanding[cls] > class_limit(cls))
					report_mismatch("class outstanding", class_limit(cls), outstanding[cls]);
				issue_classes.push_back(cls);
			end
			if (tag_busy[issue_tag]) begin
				$display("tag %0d issued again while still outstanding", issue_tag);
				error_count++;
			end
			tag_busy[issue_tag]        = 1'b1;
			tag_class_ref[issue_tag]   = cls[1:0];
			tag_address_ref[issue_tag] = issued_address;
			pending_tag.push_back(issue_tag);
			pending_due.push_back(cycle + 2 + ($unsigned($random(seed)) % 8));
		end
	end

//////////////////////////////
// host model
//////////////////////////////

	// answers in issue order once each delay has passed
	always @(negedge clock) begin : host_model
		int pick;
		int discard;
		if (host_on) begin
			if (pending_tag.size() != 0 && cycle >= pending_due[0]) begin
				pick            = $unsigned($random(seed)) % 6;
				discard         = pending_due.pop_front();
				psl_rsp_valid   = 1'b1;
				psl_rsp_tag     = pending_tag.pop_front();
				psl_rsp_credits = 8'd1;
				case (pick)
					0:       psl_rsp_code = afu_pkg::DERROR;
					1:       psl_rsp_code = afu_pkg::PAGED;
					default: psl_rsp_code = afu_pkg::DONE;
				endcase
				sent_tag.push_back(psl_rsp_tag);
				sent_code.push_back(psl_rsp_code);
			end else begin
				psl_rsp_valid = 1'b0;
			end
		end
	end

	task automatic set_host(input logic on);
		@(posedge clock);
		host_on = on;
		@(negedge clock);
	endtask

	task automatic send_response(input logic [7:0] tag, input afu_pkg::response_code_t code,
		input logic [7:0] credits);
		psl_rsp_valid   = 1'b1;
		psl_rsp_tag     = tag;
		psl_rsp_code    = code;
		psl_rsp_credits = credits;
		sent_tag.push_back(tag);
		sent_code.push_back(code);
		@(negedge clock);
		psl_rsp_valid = 1'b0;
	endtask

//////////////////////////////
// stimulus tasks
//////////////////////////////

	task automatic apply_reset();
		set_host(1'b0);
		rstn          = 1'b0;
		enabled       = 1'b0;
		cmd_valid     = 1'b0;
		psl_rsp_valid = 1'b0;
		issue_count   = 0;
		rsp_count     = 0;
		pending_tag.delete();
		pending_due.delete();
		sent_tag.delete();
		sent_code.delete();
		issue_classes.delete();
		for (int i = 0; i < 3; i++) begin
			next_sequence[i] = 0;
			outstanding[i]   = 0;
		end
		for (int i = 0; i < 256; i++)
			tag_busy[i] = 1'b0;
		repeat (4) @(negedge clock);
		rstn = 1'b1;
	endtask

	// source side respects almost full
	task automatic offer_command(input logic [1:0] cls, input int seq);
		int cycles;
		cycles = 0;
		while (cmd_almost_full[cls] && cycles < 100) begin
			@(negedge clock);
			cycles++;
		end
		if (cmd_almost_full[cls]) begin
			$display("timeout: class %0d queue stayed almost full", cls);
			timeout_count++;
		end else begin
			cmd_valid   = 1'b1;
			cmd_class   = cls;
			cmd_address = make_address(cls, seq);
			cmd_code    = class_code(cls);
			@(negedge clock);
			cmd_valid = 1'b0;
		end
	endtask

	task automatic wait_for_issues(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (issue_count < target && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (issue_count < target) begin
			$display("timeout: %0d of %0d commands issued", issue_count, target);
			timeout_count++;
		end
	endtask

	task automatic wait_for_responses(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (rsp_count < target && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (rsp_count < target) begin
			$display("timeout: %0d of %0d responses delivered", rsp_count, target);
			timeout_count++;
		end
	endtask

//////////////////////////////
// test sequence
//////////////////////////////

	initial begin : main
		logic [7:0] first_tag;
		int discard;
		int assertion_failures;
		rstn            = 1'b0;
		enabled         = 1'b0;
		cmd_valid       = 1'b0;
		cmd_class       = 2'd0;
		cmd_address     = '0;
		cmd_code        = afu_pkg::READ_CL;
		room            = 8'd0;
		psl_rsp_valid   = 1'b0;
		psl_rsp_tag     = 8'd0;
		psl_rsp_code    = afu_pkg::DONE;
		psl_rsp_credits = 8'd0;
		host_on         = 1'b0;
		error_count     = 0;
		timeout_count   = 0;
		cycle           = 0;
		apply_reset();

		// outputs quiet while idle
		repeat (6) begin
			@(negedge clock);
			if (issue_valid !== 1'b0)
				report_mismatch("idle issue_valid", 0, issue_valid);
			if (rsp_valid !== 1'b0)
				report_mismatch("idle rsp_valid", 0, rsp_valid);
			if (rsp_error !== 1'b0)
				report_mismatch("idle rsp_error", 0, rsp_error);
			if (cmd_almost_full !== 3'b000)
				report_mismatch("idle cmd_almost_full", 0, cmd_almost_full);
		end

		// room of two, four writes queued, host silent
		for (int n = 0; n < 4; n++)
			offer_command(2'd1, n);
		room    = 8'd2;
		enabled = 1'b1;
		repeat (20) @(negedge clock);
		if (issue_count != 2)
			report_mismatch("issues with room 2", 2, issue_count);
		first_tag = pending_tag.pop_front();
		discard   = pending_due.pop_front();
		send_response(first_tag, afu_pkg::DONE, 8'd1);
		wait_for_issues(3, 50);
		repeat (20) @(negedge clock);
		if (issue_count != 3)
			report_mismatch("issues after one credit", 3, issue_count);
		set_host(1'b1);
		wait_for_issues(4, 100);
		wait_for_responses(4, 200);

		// all classes loaded before enable, ample room
		apply_reset();
		for (int n = 0; n < 6; n++)
			offer_command(2'd0, n);
		for (int n = 0; n < 6; n++)
			offer_command(2'd1, n);
		for (int n = 0; n < 3; n++)
			offer_command(2'd2, n);
		if (cmd_almost_full !== 3'b011)
			report_mismatch("loaded cmd_almost_full", 3'b011, cmd_almost_full);
		room    = 8'd16;
		enabled = 1'b1;
		set_host(1'b1);
		wait_for_issues(15, 400);
		wait_for_responses(15, 600);
		if (issue_classes.size() >= 5) begin
			for (int i = 0; i < 5; i++) begin
				if (issue_classes[i] != (i % 3))
					report_mismatch("grant rotation", i % 3, issue_classes[i]);
			end
		end

		// tags nobody holds
		set_host(1'b0);
		send_response(8'd200, afu_pkg::DONE, 8'd0);
		send_response(8'd3, afu_pkg::DONE, 8'd0);
		wait_for_responses(17, 50);
		repeat (4) @(negedge clock);

		assertion_failures = afu_command_path_i.afu_command_path_assertions_i.failure_count;
		$display({"checks failed: %0d, timeouts: %0d, assertion failures: %0d, ",
			"commands issued: %0d, responses checked: %0d"},
			error_count, timeout_count, assertion_failures, issue_count, rsp_count);
		if (error_count == 0 && timeout_count == 0 && assertion_failures == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== testbench/afu_command_path_assertions.sv ====
// bound checks: quiet issue after reset, unique outstanding tags, fixed response latency
`timescale 1ns/1ps

module afu_command_path_assertions (
	input logic                          clock,
	input logic                          rstn,
	input logic                          enabled,
	input logic                          issue_valid,
	input logic [afu_pkg::TAG_WIDTH-1:0] issue_tag,
	input logic                          psl_rsp_valid,
	input logic                          rsp_valid,
	input logic [afu_pkg::TAG_WIDTH-1:0] rsp_tag
);

	// one bit per possible tag value
	logic [(1 << afu_pkg::TAG_WIDTH)-1:0] tag_busy;

	// count of failed properties
	int failure_count = 0;

	// set on issue, cleared on delivery
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			tag_busy <= '0;
		end else begin
			if (rsp_valid)
				tag_busy[rsp_tag] <= 1'b0;
			if (issue_valid)
				tag_busy[issue_tag] <= 1'b1;
		end
	end

//////////////////////////////
// properties
//////////////////////////////

	quiet_after_reset: assert property (@(posedge clock)
		$rose(rstn) |-> !issue_valid && !rsp_valid)
		else begin
			failure_count++;
			$error("issue_valid or rsp_valid high right after reset");
		end

	unique_tag: assert property (@(posedge clock) disable iff (!rstn)
		issue_valid |-> !tag_busy[issue_tag])
		else begin
			failure_count++;
			$error("tag %0d issued while still outstanding", issue_tag);
		end

	// latch then route
	response_latency: assert property (@(posedge clock) disable iff (!rstn)
		psl_rsp_valid && enabled |-> ##2 rsp_valid)
		else begin
			failure_count++;
			$error("rsp_valid missing two cycles after psl_rsp_valid");
		end

	no_stray_response: assert property (@(posedge clock) disable iff (!rstn)
		rsp_valid |-> $past(psl_rsp_valid && enabled, 2))
		else begin
			failure_count++;
			$error("rsp_valid without psl_rsp_valid two cycles before");
		end

endmodule

bind afu_command_path afu_command_path_assertions afu_command_path_assertions_i (
	.clock        (clock),
	.rstn         (rstn),
	.enabled      (enabled),
	.issue_valid  (issue_valid),
	.issue_tag    (issue_tag),
	.psl_rsp_valid(psl_rsp_valid),
	.rsp_valid    (rsp_valid),
	.rsp_tag      (rsp_tag)
);

// ==== source/afu_command_path.sv ====
// command path top level: class channels, arbiter, tag table and response router
`timescale 1ns/1ps

module afu_command_path #(
	parameter int QUEUE_DEPTH = afu_pkg::QUEUE_DEPTH,
	parameter int NUM_TAGS    = afu_pkg::NUM_TAGS,
	parameter logic [afu_pkg::NUM_CLASSES-1:0][afu_pkg::CREDIT_WIDTH-1:0] CLASS_CREDITS =
		afu_pkg::CLASS_CREDITS
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enabled,
	// compute side commands
	input  logic                               cmd_valid,
	input  logic [afu_pkg::CLASS_WIDTH-1:0]    cmd_class,
	input  logic [afu_pkg::ADDRESS_WIDTH-1:0]  cmd_address,
	input  afu_pkg::command_code_t             cmd_code,
	output logic [afu_pkg::NUM_CLASSES-1:0]    cmd_almost_full,
	// host link issue
	input  logic [afu_pkg::CREDIT_WIDTH-1:0]   room,
	output logic                               issue_valid,
	output logic [afu_pkg::TAG_WIDTH-1:0]      issue_tag,
	output logic [afu_pkg::ADDRESS_WIDTH-1:0]  issue_address,
	output afu_pkg::command_code_t             issue_code,
	// host link responses
	input  logic                               psl_rsp_valid,
	input  logic [afu_pkg::TAG_WIDTH-1:0]      psl_rsp_tag,
	input  afu_pkg::response_code_t            psl_rsp_code,
	input  logic [afu_pkg::CREDIT_WIDTH-1:0]   psl_rsp_credits,
	// delivered responses
	output logic                               rsp_valid,
	output logic [afu_pkg::CLASS_WIDTH-1:0]    rsp_class,
	output logic [afu_pkg::TAG_WIDTH-1:0]      rsp_tag,
	output afu_pkg::response_code_t            rsp_code,
	output logic [afu_pkg::ADDRESS_WIDTH-1:0]  rsp_address,
	output logic                               rsp_error
);

	channel_if links [afu_pkg::NUM_CLASSES] ();

	afu_pkg::command_word_t             push_command;
	logic                               tag_ready;
	logic                               alloc;
	logic [afu_pkg::CLASS_WIDTH-1:0]    alloc_class;
	logic [afu_pkg::ADDRESS_WIDTH-1:0]  alloc_address;
	logic [afu_pkg::TAG_WIDTH-1:0]      alloc_tag;
	logic [afu_pkg::TAG_WIDTH-1:0]      lookup_tag;
	logic [afu_pkg::CLASS_WIDTH-1:0]    lookup_class;
	logic [afu_pkg::ADDRESS_WIDTH-1:0]  lookup_address;
	logic                               lookup_hit;
	logic                               tag_release;
	logic                               total_return;
	logic [afu_pkg::CREDIT_WIDTH-1:0]   total_count;

	assign push_command.address = cmd_address;
	assign push_command.code    = cmd_code;

//////////////////////////////
// class channels
//////////////////////////////

	// cmd_class steers the push, an unused class value is dropped
	for (genvar i = 0; i < afu_pkg::NUM_CLASSES; i++) begin : gen_channels
		command_channel #(
			.QUEUE_DEPTH(QUEUE_DEPTH),
			.CLASS_LIMIT(CLASS_CREDITS[i])
		) command_channel_i (
			.clock       (clock),
			.rstn        (rstn),
			.enabled     (enabled),
			.push        (cmd_valid && (cmd_class == afu_pkg::CLASS_WIDTH'(i))),
			.push_command(push_command),
			.almost_full (cmd_almost_full[i]),
			.link        (links[i])
		);
	end

//////////////////////////////
// issue side
//////////////////////////////

	command_arbiter command_arbiter_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.room         (room),
		.channels     (links),
		.tag_ready    (tag_ready),
		.alloc        (alloc),
		.alloc_class  (alloc_class),
		.alloc_address(alloc_address),
		.alloc_tag    (alloc_tag),
		.total_return (total_return),
		.total_count  (total_count),
		.issue_valid  (issue_valid),
		.issue_tag    (issue_tag),
		.issue_address(issue_address),
		.issue_code   (issue_code)
	);

	tag_table #(
		.NUM_TAGS(NUM_TAGS)
	) tag_table_i (
		.clock         (clock),
		.rstn          (rstn),
		.alloc         (alloc),
		.alloc_class   (alloc_class),
		.alloc_address (alloc_address),
		.alloc_tag     (alloc_tag),
		.tag_ready     (tag_ready),
		.lookup_tag    (lookup_tag),
		.lookup_class  (lookup_class),
		.lookup_address(lookup_address),
		.lookup_hit    (lookup_hit),
		.tag_release   (tag_release)
	);

//////////////////////////////
// response side
//////////////////////////////

	response_router response_router_i (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.psl_rsp_valid  (psl_rsp_valid),
		.psl_rsp_tag    (psl_rsp_tag),
		.psl_rsp_code   (psl_rsp_code),
		.psl_rsp_credits(psl_rsp_credits),
		.lookup_tag     (lookup_tag),
		.lookup_class   (lookup_class),
		.lookup_address (lookup_address),
		.lookup_hit     (lookup_hit),
		.tag_release    (tag_release),
		.channels       (links),
		.total_return   (total_return),
		.total_count    (total_count),
		.rsp_valid      (rsp_valid),
		.rsp_class      (rsp_class),
		.rsp_tag        (rsp_tag),
		.rsp_code       (rsp_code),
		.rsp_address    (rsp_address),
		.rsp_error      (rsp_error)
	);

endmodule

// ==== source/response_router.sv ====
// response router: host response latch, tag lookup, credit returns, response output
`timescale 1ns/1ps

module response_router (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enabled,
	input  logic                               psl_rsp_valid,
	input  logic [afu_pkg::TAG_WIDTH-1:0]      psl_rsp_tag,
	input  afu_pkg::response_code_t            psl_rsp_code,
	input  logic [afu_pkg::CREDIT_WIDTH-1:0]   psl_rsp_credits,
	output logic [afu_pkg::TAG_WIDTH-1:0]      lookup_tag,
	input  logic [afu_pkg::CLASS_WIDTH-1:0]    lookup_class,
	input  logic [afu_pkg::ADDRESS_WIDTH-1:0]  lookup_address,
	input  logic                               lookup_hit,
	output logic                               tag_release,
	channel_if.router                          channels [afu_pkg::NUM_CLASSES],
	output logic                               total_return,
	output logic [afu_pkg::CREDIT_WIDTH-1:0]   total_count,
	output logic                               rsp_valid,
	output logic [afu_pkg::CLASS_WIDTH-1:0]    rsp_class,
	output logic [afu_pkg::TAG_WIDTH-1:0]      rsp_tag,
	output afu_pkg::response_code_t            rsp_code,
	output logic [afu_pkg::ADDRESS_WIDTH-1:0]  rsp_address,
	output logic                               rsp_error
);

	// each response gives back one class credit
	localparam logic [afu_pkg::CREDIT_WIDTH-1:0] ONE_CREDIT = 1;

	logic                               latch_valid;
	logic [afu_pkg::TAG_WIDTH-1:0]      latch_tag;
	afu_pkg::response_code_t            latch_code;
	logic [afu_pkg::CREDIT_WIDTH-1:0]   latch_credits;
	logic [afu_pkg::NUM_CLASSES-1:0]    class_return;

//////////////////////////////
// stage 1, latch
//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			latch_valid <= 1'b0;
		else
			latch_valid <= enabled && psl_rsp_valid;
	end

	always_ff @(posedge clock) begin
		latch_tag     <= psl_rsp_tag;
		latch_code    <= psl_rsp_code;
		latch_credits <= psl_rsp_credits;
	end

	// table answers in this same cycle
	assign lookup_tag  = latch_tag;
	assign tag_release = latch_valid && lookup_hit;

//////////////////////////////
// stage 2, route
//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_valid    <= 1'b0;
			rsp_error    <= 1'b0;
			class_return <= '0;
		end else begin
			rsp_valid <= latch_valid;
			// paged, fault and flushed come out as plain errors
			rsp_error <= latch_valid && ((latch_code != afu_pkg::DONE) || !lookup_hit);
			for (int i = 0; i < afu_pkg::NUM_CLASSES; i++)
				class_return[i] <= tag_release && (lookup_class == afu_pkg::CLASS_WIDTH'(i));
		end
	end

	always_ff @(posedge clock) begin
		rsp_class   <= lookup_class;
		rsp_tag     <= latch_tag;
		rsp_code    <= latch_code;
		rsp_address <= lookup_address;
		total_count <= latch_credits;
	end

	// host credits come back with every response, known tag or not
	assign total_return = rsp_valid;

	for (genvar i = 0; i < afu_pkg::NUM_CLASSES; i++) begin : gen_returns
		assign channels[i].credit_return = class_return[i];
		assign channels[i].credit_count  = ONE_CREDIT;
	end

endmodule

// ==== source/tag_table.sv ====
// tag table: free tag allocation, per-tag class and address, tag lookup
`timescale 1ns/1ps

module tag_table #(
	parameter int NUM_TAGS = afu_pkg::NUM_TAGS
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               alloc,
	input  logic [afu_pkg::CLASS_WIDTH-1:0]    alloc_class,
	input  logic [afu_pkg::ADDRESS_WIDTH-1:0]  alloc_address,
	output logic [afu_pkg::TAG_WIDTH-1:0]      alloc_tag,
	output logic                               tag_ready,
	input  logic [afu_pkg::TAG_WIDTH-1:0]      lookup_tag,
	output logic [afu_pkg::CLASS_WIDTH-1:0]    lookup_class,
	output logic [afu_pkg::ADDRESS_WIDTH-1:0]  lookup_address,
	output logic                               lookup_hit,
	input  logic                               tag_release
);

	localparam int INDEX_WIDTH = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

	logic [NUM_TAGS-1:0]                tag_valid;
	logic [afu_pkg::CLASS_WIDTH-1:0]    tag_class   [NUM_TAGS];
	logic [afu_pkg::ADDRESS_WIDTH-1:0]  tag_address [NUM_TAGS];
	logic [INDEX_WIDTH-1:0]             free_index;
	logic [INDEX_WIDTH-1:0]             lookup_index;

	// lowest free slot wins
	always_comb begin
		free_index = '0;
		for (int i = NUM_TAGS - 1; i >= 0; i--) begin
			if (!tag_valid[i])
				free_index = INDEX_WIDTH'(i);
		end
		alloc_tag = '0;
		alloc_tag[INDEX_WIDTH-1:0] = free_index;
	end

	assign tag_ready = ~&tag_valid;

	// lookup path for the router
	assign lookup_index   = lookup_tag[INDEX_WIDTH-1:0];
	assign lookup_hit     = (lookup_tag < NUM_TAGS) && tag_valid[lookup_index];
	assign lookup_class   = tag_class[lookup_index];
	assign lookup_address = tag_address[lookup_index];

	// alloc and release never hit the same slot
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			tag_valid <= '0;
		end else begin
			if (alloc)
				tag_valid[free_index] <= 1'b1;
			if (tag_release)
				tag_valid[lookup_index] <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (alloc) begin
			tag_class[free_index]   <= alloc_class;
			tag_address[free_index] <= alloc_address;
		end
	end

endmodule

// ==== source/command_arbiter.sv ====
// command arbiter: round-robin class pick, link credit total, tag request, issue register
`timescale 1ns/1ps

module command_arbiter (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enabled,
	input  logic [afu_pkg::CREDIT_WIDTH-1:0]   room,
	channel_if.arbiter                         channels [afu_pkg::NUM_CLASSES],
	input  logic                               tag_ready,
	output logic                               alloc,
	output logic [afu_pkg::CLASS_WIDTH-1:0]    alloc_class,
	output logic [afu_pkg::ADDRESS_WIDTH-1:0]  alloc_address,
	input  logic [afu_pkg::TAG_WIDTH-1:0]      alloc_tag,
	input  logic                               total_return,
	input  logic [afu_pkg::CREDIT_WIDTH-1:0]   total_count,
	output logic                               issue_valid,
	output logic [afu_pkg::TAG_WIDTH-1:0]      issue_tag,
	output logic [afu_pkg::ADDRESS_WIDTH-1:0]  issue_address,
	output afu_pkg::command_code_t             issue_code
);

	logic [afu_pkg::NUM_CLASSES-1:0]    request;
	afu_pkg::command_word_t             command [afu_pkg::NUM_CLASSES];
	logic [afu_pkg::CLASS_WIDTH-1:0]    last_class;
	logic [afu_pkg::CLASS_WIDTH-1:0]    winner;
	logic [afu_pkg::CREDIT_WIDTH-1:0]   total;
	logic [afu_pkg::CREDIT_WIDTH-1:0]   total_in;
	logic                               enabled_q;
	logic                               fire;

	// gather requests, hand back pops
	for (genvar i = 0; i < afu_pkg::NUM_CLASSES; i++) begin : gen_ports
		assign request[i]       = channels[i].request;
		assign command[i]       = channels[i].command;
		assign channels[i].grant = fire && (winner == afu_pkg::CLASS_WIDTH'(i));
	end

//////////////////////////////
// round robin
//////////////////////////////

	// search starts one past the last granted class
	always_comb begin
		int  candidate;
		logic found;
		winner = last_class;
		found  = 1'b0;
		for (int offset = 1; offset <= afu_pkg::NUM_CLASSES; offset++) begin
			candidate = (int'(last_class) + offset) % afu_pkg::NUM_CLASSES;
			if (!found && request[candidate]) begin
				winner = afu_pkg::CLASS_WIDTH'(candidate);
				found  = 1'b1;
			end
		end
	end

	// link credit, free tag and a requester all needed
	assign fire = (total != '0) && tag_ready && (|request);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			last_class <= afu_pkg::CLASS_WED;
		else if (fire)
			last_class <= winner;
	end

//////////////////////////////
// link credit total
//////////////////////////////

	assign total_in = total_return ? total_count : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_q <= 1'b0;
			total     <= '0;
		end else begin
			enabled_q <= enabled;
			// host room taken once at enable
			if (enabled && !enabled_q)
				total <= room;
			else
				total <= total + total_in - {{(afu_pkg::CREDIT_WIDTH-1){1'b0}}, fire};
		end
	end

//////////////////////////////
// tag request and issue
//////////////////////////////

	assign alloc         = fire;
	assign alloc_class   = winner;
	assign alloc_address = command[winner].address;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			issue_valid <= 1'b0;
		else
			issue_valid <= fire;
	end

	// payload follows issue_valid
	always_ff @(posedge clock) begin
		if (fire) begin
			issue_tag     <= alloc_tag;
			issue_address <= command[winner].address;
			issue_code    <= command[winner].code;
		end
	end

endmodule

// ==== source/command_channel.sv ====
// command channel: class queue, almost-full flag and class credit counter
`timescale 1ns/1ps

module command_channel #(
	parameter int                               QUEUE_DEPTH = afu_pkg::QUEUE_DEPTH,
	parameter logic [afu_pkg::CREDIT_WIDTH-1:0] CLASS_LIMIT = 1
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   push,
	input  afu_pkg::command_word_t push_command,
	output logic                   almost_full,
	channel_if.channel             link
);

	localparam int POINTER_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int COUNT_WIDTH   = $clog2(QUEUE_DEPTH + 1);
	localparam logic [COUNT_WIDTH-1:0] FULL_LEVEL = COUNT_WIDTH'(QUEUE_DEPTH);
	localparam logic [COUNT_WIDTH-1:0] ALMOST_FULL_LEVEL =
		COUNT_WIDTH'(QUEUE_DEPTH - afu_pkg::QUEUE_HEADROOM);

	afu_pkg::command_word_t             queue [QUEUE_DEPTH];
	logic [POINTER_WIDTH-1:0]           write_pointer;
	logic [POINTER_WIDTH-1:0]           read_pointer;
	logic [COUNT_WIDTH-1:0]             count;
	logic [afu_pkg::CREDIT_WIDTH-1:0]   credits;
	logic [afu_pkg::CREDIT_WIDTH-1:0]   credit_in;
	logic                               enabled_q;
	logic                               accept;
	logic                               pop;

//////////////////////////////
// queue
//////////////////////////////

	// offered command on a full queue is lost
	assign accept      = push && (count != FULL_LEVEL);
	assign pop         = link.grant;
	assign almost_full = (count >= ALMOST_FULL_LEVEL);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_pointer <= '0;
			read_pointer  <= '0;
			count         <= '0;
		end else begin
			if (accept) begin
				if (write_pointer == POINTER_WIDTH'(QUEUE_DEPTH - 1))
					write_pointer <= '0;
				else
					write_pointer <= write_pointer + 1'b1;
			end
			if (pop) begin
				if (read_pointer == POINTER_WIDTH'(QUEUE_DEPTH - 1))
					read_pointer <= '0;
				else
					read_pointer <= read_pointer + 1'b1;
			end
			// net occupancy change
			case ({accept, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage only
	always_ff @(posedge clock) begin
		if (accept)
			queue[write_pointer] <= push_command;
	end

	assign link.command = queue[read_pointer];

//////////////////////////////
// class credits
//////////////////////////////

	assign credit_in = link.credit_return ? link.credit_count : '0;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_q <= 1'b0;
			credits   <= '0;
		end else begin
			enabled_q <= enabled;
			// limit loaded once on the rising enable
			if (enabled && !enabled_q)
				credits <= CLASS_LIMIT;
			else
				credits <= credits + credit_in - {{(afu_pkg::CREDIT_WIDTH-1){1'b0}}, pop};
		end
	end

	// head of queue is ready and the class may spend
	assign link.request = (count != '0) && (credits != '0);

endmodule

// ==== source/channel_if.sv ====
// class channel interface with channel, arbiter and router modports
`timescale 1ns/1ps

interface channel_if;

	// channel side
	logic                   request;
	afu_pkg::command_word_t command;

	// arbiter pop, one cycle
	logic grant;

	// credits back from the response side
	logic                              credit_return;
	logic [afu_pkg::CREDIT_WIDTH-1:0] credit_count;

	modport channel (
		output request,
		output command,
		input  grant,
		input  credit_return,
		input  credit_count
	);

	modport arbiter (
		input  request,
		input  command,
		output grant
	);

	modport router (
		output credit_return,
		output credit_count
	);

endinterface

// ==== source/afu_pkg.sv ====
// widths, class indices, credit limits, host command and response codes, queue word
package afu_pkg;

	localparam int ADDRESS_WIDTH = 64;
	localparam int TAG_WIDTH     = 8;
	localparam int NUM_TAGS      = 16;
	localparam int NUM_CLASSES   = 3;
	localparam int CLASS_WIDTH   = 2;
	localparam int CREDIT_WIDTH  = 8;

	// class queue sizing
	localparam int QUEUE_DEPTH    = 8;
	localparam int QUEUE_HEADROOM = 2;

	// class indices, also the round-robin order
	localparam logic [CLASS_WIDTH-1:0] CLASS_READ  = 2'd0;
	localparam logic [CLASS_WIDTH-1:0] CLASS_WRITE = 2'd1;
	localparam logic [CLASS_WIDTH-1:0] CLASS_WED   = 2'd2;

	// per-class limits, element 0 is read
	localparam logic [NUM_CLASSES-1:0][CREDIT_WIDTH-1:0] CLASS_CREDITS = {
		8'd1,
		8'd4,
		8'd4
	};

	typedef enum logic [12:0] {
		READ_CL  = 13'h0A50,
		WRITE_MI = 13'h0D60,
		READ_WED = 13'h0A00
	} command_code_t;

	typedef enum logic [7:0] {
		DONE    = 8'h00,
		AERROR  = 8'h01,
		DERROR  = 8'h03,
		NLOCK   = 8'h04,
		NRES    = 8'h05,
		FLUSHED = 8'h06,
		FAULT   = 8'h07,
		FAILED  = 8'h08,
		PAGED   = 8'h0A
	} response_code_t;

	// one queued command
	typedef struct packed {
		logic [ADDRESS_WIDTH-1:0] address;
		command_code_t            code;
	} command_word_t;

endpackage
